//--- source/soc_pkg.sv
`default_nettype none

package soc_pkg;

    localparam int ALEN   = 32;
    localparam int XLEN   = 32;
    localparam int STRB_W = XLEN / 8;
    localparam int OFS_W  = ALEN - 4;  // Offset within a region.

    // Top nibble of the address.
    localparam logic [3:0] REGION_SRAM = 4'h0;
    localparam logic [3:0] REGION_GPIO = 4'h1;

    localparam logic [3:0] GPIO_OUT_OFS = 4'h0;
    localparam logic [3:0] GPIO_IN_OFS  = 4'h4;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_SRAM,
        DEV_GPIO
    } dev_sel_e;

    function automatic dev_sel_e addr_region(input logic [ALEN-1:0] addr);
        case (addr[ALEN-1 -: 4])
            REGION_SRAM: return DEV_SRAM;
            REGION_GPIO: return DEV_GPIO;
            default:     return DEV_NONE;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/axil_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module axil_decoder (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        wvalid,
    output logic                        wready,
    input  logic [soc_pkg::ALEN-1:0]    waddr,
    input  logic [soc_pkg::XLEN-1:0]    wdata,
    input  logic [soc_pkg::STRB_W-1:0]  wstrb,
    output logic                        bvalid,
    output soc_pkg::resp_e              bresp,

    input  logic                        arvalid,
    output logic                        arready,
    input  logic [soc_pkg::ALEN-1:0]    araddr,
    output logic                        rvalid,
    output soc_pkg::resp_e              rresp,
    output logic [soc_pkg::XLEN-1:0]    rdata,

    output logic [soc_pkg::OFS_W-1:0]   dev_wr_addr,
    output logic [soc_pkg::XLEN-1:0]    dev_wr_data,
    output logic [soc_pkg::STRB_W-1:0]  dev_wr_strb,
    output logic [soc_pkg::OFS_W-1:0]   dev_rd_addr,

    output logic                        sram_wr_en,
    output logic                        sram_rd_en,
    input  logic [soc_pkg::XLEN-1:0]    sram_rd_data,

    output logic                        gpio_wr_en,
    output logic                        gpio_rd_en,
    input  logic [soc_pkg::XLEN-1:0]    gpio_rd_data,
    input  logic                        gpio_wr_err,
    input  logic                        gpio_rd_err
);
    import soc_pkg::*;

    logic     w_acc;
    logic     r_acc;
    dev_sel_e w_sel;
    dev_sel_e r_sel;
    dev_sel_e w_sel_q;
    dev_sel_e r_sel_q;

    // One transaction in flight per direction.
    assign wready = !bvalid;
    assign arready = !rvalid;

    assign w_acc = wvalid && wready;
    assign r_acc = arvalid && arready;

    assign w_sel = addr_region(waddr);
    assign r_sel = addr_region(araddr);

    // Devices only see the offset inside their region.
    assign dev_wr_addr = waddr[OFS_W-1:0];
    assign dev_wr_data = wdata;
    assign dev_wr_strb = wstrb;
    assign dev_rd_addr = araddr[OFS_W-1:0];

    assign sram_wr_en = w_acc && (w_sel == DEV_SRAM);
    assign gpio_wr_en = w_acc && (w_sel == DEV_GPIO);
    assign sram_rd_en = r_acc && (r_sel == DEV_SRAM);
    assign gpio_rd_en = r_acc && (r_sel == DEV_GPIO);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid  <= 1'b0;
            w_sel_q <= DEV_NONE;
        end else begin
            bvalid <= w_acc;  // Single-cycle pulse.
            if (w_acc) begin
                w_sel_q <= w_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid  <= 1'b0;
            r_sel_q <= DEV_NONE;
        end else begin
            rvalid <= r_acc;
            if (r_acc) begin
                r_sel_q <= r_sel;
            end
        end
    end

    always_comb begin
        case (w_sel_q)
            DEV_SRAM: bresp = OKAY;  // SRAM never errors.
            DEV_GPIO: bresp = gpio_wr_err ? SLVERR : OKAY;
            default:  bresp = DECERR;
        endcase
    end

    // Error responses always carry zero data.
    always_comb begin
        rresp = DECERR;
        rdata = '0;
        case (r_sel_q)
            DEV_SRAM: begin
                rresp = OKAY;
                rdata = sram_rd_data;
            end
            DEV_GPIO: begin
                rresp = gpio_rd_err ? SLVERR : OKAY;
                rdata = gpio_rd_err ? '0 : gpio_rd_data;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/axil_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axil_sram #(
    parameter int SRAM_SIZE_KB = 8
) (
    input  logic                        clk,

    input  logic                        wr_en,
    input  logic [soc_pkg::OFS_W-1:0]   wr_addr,
    input  logic [soc_pkg::XLEN-1:0]    wr_data,
    input  logic [soc_pkg::STRB_W-1:0]  wr_strb,

    input  logic                        rd_en,
    input  logic [soc_pkg::OFS_W-1:0]   rd_addr,
    output logic [soc_pkg::XLEN-1:0]    rd_data
);
    import soc_pkg::*;

    // 256 words of 4 bytes per kilobyte.
    localparam int DEPTH = SRAM_SIZE_KB * 256;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [XLEN-1:0]  mem [DEPTH];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // Word address wraps, so the upper part of the region aliases.
    assign wr_idx = IDX_W'(wr_addr[OFS_W-1:2] % DEPTH);
    assign rd_idx = IDX_W'(rd_addr[OFS_W-1:2] % DEPTH);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
                end
            end
        end
    end

    // Registered read, data valid the cycle after rd_en.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- source/axil_gpio.sv
`timescale 1ns/1ps
`default_nettype none

module axil_gpio #(
    parameter int GPIO_OUTPUTS = 4,
    parameter int GPIO_INPUTS  = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        wr_en,
    input  logic [soc_pkg::OFS_W-1:0]   wr_addr,
    input  logic [soc_pkg::XLEN-1:0]    wr_data,
    input  logic [soc_pkg::STRB_W-1:0]  wr_strb,
    output logic                        wr_err,

    input  logic                        rd_en,
    input  logic [soc_pkg::OFS_W-1:0]   rd_addr,
    output logic [soc_pkg::XLEN-1:0]    rd_data,
    output logic                        rd_err,

    input  logic [GPIO_INPUTS-1:0]      gpio_inputs,
    output logic [GPIO_OUTPUTS-1:0]     gpio_outputs
);
    import soc_pkg::*;

    logic                    wr_out_hit;
    logic                    rd_out_hit;
    logic                    rd_in_hit;
    logic [XLEN-1:0]         out_merged;
    logic [GPIO_INPUTS-1:0]  in_meta;
    logic [GPIO_INPUTS-1:0]  in_sync;

    // Register select uses address bits [3:2] only.
    assign wr_out_hit = (wr_addr[3:2] == GPIO_OUT_OFS[3:2]);
    assign rd_out_hit = (rd_addr[3:2] == GPIO_OUT_OFS[3:2]);
    assign rd_in_hit  = (rd_addr[3:2] == GPIO_IN_OFS[3:2]);

    always_comb begin
        out_merged = XLEN'(gpio_outputs);
        for (int i = 0; i < STRB_W; i++) begin
            if (wr_strb[i]) begin
                out_merged[i*8 +: 8] = wr_data[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_outputs <= '0;
            wr_err       <= 1'b0;
        end else begin
            wr_err <= wr_en && !wr_out_hit;  // Input reg is read only.
            if (wr_en && wr_out_hit) begin
                gpio_outputs <= out_merged[GPIO_OUTPUTS-1:0];
            end
        end
    end

    // Two-flop synchronizer.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_inputs;
            in_sync <= in_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_err <= 1'b0;
        end else begin
            rd_err <= rd_en && !(rd_out_hit || rd_in_hit);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (rd_out_hit) begin
                rd_data <= XLEN'(gpio_outputs);
            end else if (rd_in_hit) begin
                rd_data <= XLEN'(in_sync);
            end else begin
                rd_data <= '0;  // Bad offset.
            end
        end
    end

endmodule

`default_nettype wire

//--- source/basic_soc.sv
`timescale 1ns/1ps
`default_nettype none

module basic_soc #(
    parameter int SRAM_SIZE_KB = 8,
    parameter int GPIO_OUTPUTS = 4,
    parameter int GPIO_INPUTS  = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // Write request and response.
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [soc_pkg::ALEN-1:0]    waddr,
    input  logic [soc_pkg::XLEN-1:0]    wdata,
    input  logic [soc_pkg::STRB_W-1:0]  wstrb,
    output logic                        bvalid,
    output soc_pkg::resp_e              bresp,

    // Read request and response.
    input  logic                        arvalid,
    output logic                        arready,
    input  logic [soc_pkg::ALEN-1:0]    araddr,
    output logic                        rvalid,
    output soc_pkg::resp_e              rresp,
    output logic [soc_pkg::XLEN-1:0]    rdata,

    input  logic [GPIO_INPUTS-1:0]      gpio_inputs,
    output logic [GPIO_OUTPUTS-1:0]     gpio_outputs
);
    import soc_pkg::*;

    logic [OFS_W-1:0]  dev_wr_addr;
    logic [XLEN-1:0]   dev_wr_data;
    logic [STRB_W-1:0] dev_wr_strb;
    logic [OFS_W-1:0]  dev_rd_addr;
    logic              sram_wr_en;
    logic              sram_rd_en;
    logic [XLEN-1:0]   sram_rd_data;
    logic              gpio_wr_en;
    logic              gpio_rd_en;
    logic [XLEN-1:0]   gpio_rd_data;
    logic              gpio_wr_err;
    logic              gpio_rd_err;

    axil_decoder u_decoder (
        .clk,
        .rst_n,
        .wvalid,
        .wready,
        .waddr,
        .wdata,
        .wstrb,
        .bvalid,
        .bresp,
        .arvalid,
        .arready,
        .araddr,
        .rvalid,
        .rresp,
        .rdata,
        .dev_wr_addr,
        .dev_wr_data,
        .dev_wr_strb,
        .dev_rd_addr,
        .sram_wr_en,
        .sram_rd_en,
        .sram_rd_data,
        .gpio_wr_en,
        .gpio_rd_en,
        .gpio_rd_data,
        .gpio_wr_err,
        .gpio_rd_err
    );

    axil_sram #(
        .SRAM_SIZE_KB(SRAM_SIZE_KB)
    ) u_sram (
        .clk,
        .wr_en   (sram_wr_en),
        .wr_addr (dev_wr_addr),
        .wr_data (dev_wr_data),
        .wr_strb (dev_wr_strb),
        .rd_en   (sram_rd_en),
        .rd_addr (dev_rd_addr),
        .rd_data (sram_rd_data)
    );

    axil_gpio #(
        .GPIO_OUTPUTS(GPIO_OUTPUTS),
        .GPIO_INPUTS (GPIO_INPUTS)
    ) u_gpio (
        .clk,
        .rst_n,
        .wr_en        (gpio_wr_en),
        .wr_addr      (dev_wr_addr),
        .wr_data      (dev_wr_data),
        .wr_strb      (dev_wr_strb),
        .wr_err       (gpio_wr_err),
        .rd_en        (gpio_rd_en),
        .rd_addr      (dev_rd_addr),
        .rd_data      (gpio_rd_data),
        .rd_err       (gpio_rd_err),
        .gpio_inputs,
        .gpio_outputs
    );

endmodule

`default_nettype wire

//--- dv/basic_soc_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module basic_soc_asserts (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     wvalid,
    input logic                     wready,
    input logic                     bvalid,
    input logic                     arvalid,
    input logic                     arready,
    input logic                     rvalid,
    input soc_pkg::resp_e           rresp,
    input logic [soc_pkg::XLEN-1:0] rdata
);
    import soc_pkg::*;

    logic bad_w_latency = 1'b0;
    logic bad_r_latency = 1'b0;
    logic bad_ready     = 1'b0;
    logic bad_w_orphan  = 1'b0;
    logic bad_r_orphan  = 1'b0;
    logic bad_err_data  = 1'b0;
    logic bad_reset     = 1'b0;
    logic failed;

    assign failed = bad_w_latency | bad_r_latency | bad_ready | bad_w_orphan
                  | bad_r_orphan | bad_err_data | bad_reset;

    w_latency: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && wready |=> bvalid)
        else begin
            bad_w_latency = 1'b1;
            $error("write response missing one cycle after acceptance");
        end

    r_latency: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready |=> rvalid)
        else begin
            bad_r_latency = 1'b1;
            $error("read response missing one cycle after acceptance");
        end

    // Ready drops while its own response is out.
    ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        !(bvalid && wready) && !(rvalid && arready))
        else begin
            bad_ready = 1'b1;
            $error("ready high during a response");
        end

    w_orphan: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> $past(wvalid && wready))
        else begin
            bad_w_orphan = 1'b1;
            $error("write response without an accepted write");
        end

    r_orphan: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> $past(arvalid && arready))
        else begin
            bad_r_orphan = 1'b1;
            $error("read response without an accepted read");
        end

    err_data: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && (rresp != OKAY) |-> rdata == '0)
        else begin
            bad_err_data = 1'b1;
            $error("nonzero rdata on an error response");
        end

    reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !bvalid && !rvalid && wready && arready)
        else begin
            bad_reset = 1'b1;
            $error("bus outputs not idle after reset");
        end

endmodule

bind basic_soc basic_soc_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rresp   (rresp),
    .rdata   (rdata)
);

`default_nettype wire

//--- dv/tb_basic_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_basic_soc;
    import soc_pkg::*;

    localparam int SRAM_SIZE_KB = 8;
    localparam int GPIO_OUTPUTS = 4;
    localparam int GPIO_INPUTS  = 4;
    localparam int SRAM_BYTES   = SRAM_SIZE_KB * 1024;
    localparam int TIMEOUT      = 20;  // Cycles per wait loop.
    localparam logic [ALEN-1:0] GPIO_OUT_ADDR = {REGION_GPIO, 24'h0, GPIO_OUT_OFS};
    localparam logic [ALEN-1:0] GPIO_IN_ADDR  = {REGION_GPIO, 24'h0, GPIO_IN_OFS};

    logic                    clk;
    logic                    rst_n;
    logic                    wvalid;
    logic                    wready;
    logic [ALEN-1:0]         waddr;
    logic [XLEN-1:0]         wdata;
    logic [STRB_W-1:0]       wstrb;
    logic                    bvalid;
    resp_e                   bresp;
    logic                    arvalid;
    logic                    arready;
    logic [ALEN-1:0]         araddr;
    logic                    rvalid;
    resp_e                   rresp;
    logic [XLEN-1:0]         rdata;
    logic [GPIO_INPUTS-1:0]  gpio_inputs;
    logic [GPIO_OUTPUTS-1:0] gpio_outputs;

    logic [7:0]              sram_model [SRAM_BYTES];
    bit                      sram_known [SRAM_BYTES];
    logic [GPIO_OUTPUTS-1:0] gpio_model = '0;
    logic [31:0]             lcg_state = 32'd57264;

    basic_soc #(
        .SRAM_SIZE_KB(SRAM_SIZE_KB),
        .GPIO_OUTPUTS(GPIO_OUTPUTS),
        .GPIO_INPUTS (GPIO_INPUTS)
    ) u_dut (
        .clk, .rst_n,
        .wvalid, .wready, .waddr, .wdata, .wstrb, .bvalid, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rresp, .rdata,
        .gpio_inputs, .gpio_outputs
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};  // Good bits low.
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic check_eq(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
        assert (got === exp) else
            stop_run($sformatf("FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                               $time, what, got, exp));
    endtask

    task automatic check_resp(input resp_e got, input resp_e exp, input string what);
        check_eq(XLEN'(got), XLEN'(exp), what);
    endtask

    // Byte address of the word, wrapped into the SRAM size.
    function automatic int sram_base(input logic [ALEN-1:0] addr);
        return int'({addr[OFS_W-1:2], 2'b00}) % SRAM_BYTES;
    endfunction

    task automatic record_write(input logic [ALEN-1:0] addr, input logic [XLEN-1:0] data,
                                input logic [STRB_W-1:0] strb);
        int base;
        base = sram_base(addr);
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                sram_model[base + i] = data[i*8 +: 8];
                sram_known[base + i] = 1'b1;
            end
        end
    endtask

    // Bytes never written are not predicted.
    function automatic logic [XLEN-1:0] expected_word(input logic [ALEN-1:0] addr,
                                                      input logic [XLEN-1:0] got);
        logic [XLEN-1:0] exp;
        int              base;
        base = sram_base(addr);
        exp  = got;
        for (int i = 0; i < STRB_W; i++) begin
            if (sram_known[base + i]) begin
                exp[i*8 +: 8] = sram_model[base + i];
            end
        end
        return exp;
    endfunction

    function automatic logic [GPIO_OUTPUTS-1:0] merge_gpio(
            input logic [GPIO_OUTPUTS-1:0] cur, input logic [XLEN-1:0] data,
            input logic [STRB_W-1:0] strb);
        logic [XLEN-1:0] word;
        word = XLEN'(cur);
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                word[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return word[GPIO_OUTPUTS-1:0];
    endfunction

    task automatic do_write(input logic [ALEN-1:0] addr, input logic [XLEN-1:0] data,
                            input logic [STRB_W-1:0] strb, output resp_e resp);
        int n;
        @(posedge clk);
        wvalid <= 1'b1;
        waddr  <= addr;
        wdata  <= data;
        wstrb  <= strb;
        n = 0;
        @(negedge clk);
        while (!wready) begin
            n++;
            if (n > TIMEOUT) begin
                stop_run("timeout waiting for wready");
            end else begin
                @(negedge clk);
            end
        end
        @(posedge clk);  // Accepted here.
        wvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
            n++;
            if (n > TIMEOUT) begin
                stop_run("timeout waiting for the write response");
            end else begin
                @(negedge clk);
            end
        end
        resp = bresp;
    endtask

    task automatic do_read(input logic [ALEN-1:0] addr, output resp_e resp,
                           output logic [XLEN-1:0] data);
        int n;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        n = 0;
        @(negedge clk);
        while (!arready) begin
            n++;
            if (n > TIMEOUT) begin
                stop_run("timeout waiting for arready");
            end else begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        arvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
            n++;
            if (n > TIMEOUT) begin
                stop_run("timeout waiting for the read response");
            end else begin
                @(negedge clk);
            end
        end
        resp = rresp;
        data = rdata;
    endtask

    always @(negedge clk) begin
        if (u_dut.u_asserts.failed) begin
            stop_run("a bound protocol assertion on basic_soc failed");
        end
    end

    initial begin
        logic [ALEN-1:0]        a;
        logic [ALEN-1:0]        b;
        logic [XLEN-1:0]        d;
        logic [XLEN-1:0]        got;
        logic [STRB_W-1:0]      s;
        logic [GPIO_INPUTS-1:0] din;
        resp_e                  r;
        resp_e                  r2;

        rst_n       = 1'b0;
        wvalid      = 1'b0;
        waddr       = '0;
        wdata       = '0;
        wstrb       = '0;
        arvalid     = 1'b0;
        araddr      = '0;
        gpio_inputs = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_eq(XLEN'({bvalid, rvalid, wready, arready}), 32'h3, "handshakes after reset");
        check_eq(XLEN'(gpio_outputs), '0, "gpio_outputs after reset");

        // Aliased readback covers addresses up to four times the SRAM size.
        for (int k = 0; k < 200; k++) begin
            a = {REGION_SRAM, OFS_W'(next_rand() % (4 * SRAM_BYTES))};
            d = next_rand();
            s = STRB_W'(next_rand());
            do_write(a, d, s, r);
            check_resp(r, OKAY, "SRAM write response");
            record_write(a, d, s);
            b = a + ALEN'(SRAM_BYTES * (next_rand() % 4));
            do_read(b, r, got);
            check_resp(r, OKAY, "SRAM read response");
            check_eq(got, expected_word(b, got), "SRAM read data");
        end

        for (int k = 0; k < 8; k++) begin
            d = next_rand();
            s = STRB_W'(next_rand());
            do_write(GPIO_OUT_ADDR, d, s, r);
            check_resp(r, OKAY, "GPIO write response");
            gpio_model = merge_gpio(gpio_model, d, s);
            check_eq(XLEN'(gpio_outputs), XLEN'(gpio_model), "gpio_outputs");
            do_read(GPIO_OUT_ADDR, r, got);
            check_resp(r, OKAY, "GPIO readback response");
            check_eq(got, XLEN'(gpio_model), "GPIO readback data");
        end

        for (int k = 0; k < 4; k++) begin
            din = GPIO_INPUTS'(next_rand());
            @(posedge clk);
            gpio_inputs <= din;
            repeat (3) @(posedge clk);
            do_read(GPIO_IN_ADDR, r, got);
            check_resp(r, OKAY, "GPIO input response");
            check_eq(got, XLEN'(din), "GPIO input data");
        end

        // Same offset in every unmapped region must leave the SRAM word alone.
        for (int rg = 2; rg < 16; rg++) begin
            a = {REGION_SRAM, OFS_W'(next_rand() % SRAM_BYTES)};
            d = next_rand();
            do_write(a, d, {STRB_W{1'b1}}, r);
            check_resp(r, OKAY, "SRAM write response");
            record_write(a, d, {STRB_W{1'b1}});
            b = {4'(rg), a[OFS_W-1:0]};
            do_write(b, ~d, {STRB_W{1'b1}}, r);
            check_resp(r, DECERR, "unmapped write response");
            do_read(b, r, got);
            check_resp(r, DECERR, "unmapped read response");
            check_eq(got, '0, "unmapped read data");
            do_read(a, r, got);
            check_resp(r, OKAY, "SRAM read response");
            check_eq(got, expected_word(a, got), "SRAM data after unmapped write");
        end
        check_eq(XLEN'(gpio_outputs), XLEN'(gpio_model), "gpio_outputs after unmapped writes");

        for (int k = 1; k < 4; k++) begin
            b = {REGION_GPIO, 24'h0, 4'(k * 4)};
            do_write(b, next_rand(), {STRB_W{1'b1}}, r);
            check_resp(r, SLVERR, "bad GPIO write response");
            check_eq(XLEN'(gpio_outputs), XLEN'(gpio_model), "gpio_outputs after bad write");
            if (k > 1) begin
                do_read(b, r, got);
                check_resp(r, SLVERR, "bad GPIO read response");
                check_eq(got, '0, "bad GPIO read data");
            end
        end

        d = next_rand();
        s = STRB_W'(next_rand());
        fork
            do_write(GPIO_OUT_ADDR, d, s, r);
            do_read(a, r2, got);
        join
        gpio_model = merge_gpio(gpio_model, d, s);
        check_resp(r, OKAY, "concurrent GPIO write response");
        check_resp(r2, OKAY, "concurrent SRAM read response");
        check_eq(got, expected_word(a, got), "concurrent SRAM read data");
        check_eq(XLEN'(gpio_outputs), XLEN'(gpio_model), "gpio_outputs after concurrent write");
        d = next_rand();
        fork
            do_write(a, d, {STRB_W{1'b1}}, r);
            do_read(GPIO_OUT_ADDR, r2, got);
        join
        record_write(a, d, {STRB_W{1'b1}});
        check_resp(r, OKAY, "concurrent SRAM write response");
        check_resp(r2, OKAY, "concurrent GPIO read response");
        check_eq(got, XLEN'(gpio_model), "concurrent GPIO read data");
        do_read(a, r, got);
        check_resp(r, OKAY, "SRAM read response");
        check_eq(got, expected_word(a, got), "SRAM data after concurrent write");

        @(negedge clk);
        if (u_dut.u_asserts.failed) begin
            stop_run("a bound protocol assertion on basic_soc failed");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
source/soc_pkg.sv
source/axil_decoder.sv
source/axil_sram.sv
source/axil_gpio.sv
source/basic_soc.sv
dv/basic_soc_asserts.sv
dv/tb_basic_soc.sv

//--- Makefile
TOP       ?= tb_basic_soc
FILELIST  ?= tb.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
